//--- files.f
verilog/pf_pkg.sv
verilog/pf_req_if.sv
verilog/pf_table.sv
verilog/pf_predictor.sv
verilog/pf_issue_fsm.sv
verilog/pf_throttle.sv
verilog/data_prefetch_top.sv
sim/pf_clk_gen.sv
sim/data_prefetch_checker.sv
sim/data_prefetch_tb.sv

//--- Bender.yml
package:
  name: data_prefetch

sources:
  - verilog/pf_pkg.sv
  - verilog/pf_req_if.sv
  - verilog/pf_table.sv
  - verilog/pf_predictor.sv
  - verilog/pf_issue_fsm.sv
  - verilog/pf_throttle.sv
  - verilog/data_prefetch_top.sv
  - target: simulation
    files:
      - sim/pf_clk_gen.sv
      - sim/data_prefetch_checker.sv
      - sim/data_prefetch_tb.sv

//--- sim/data_prefetch_tb.sv
`timescale 1ns/1ps

module data_prefetch_tb import pf_pkg::*;
();

    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        arst_n;
    logic        acc_valid;
    pc_t         acc_pc;
    addr_t       acc_addr;
    logic        fb_valid;
    pc_t         fb_pc;
    pf_kind_e    fb_kind;
    logic        fb_useful;
    addr_t       araddr;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    // reference model of tables, counters, throttle and issuer
    addr_t stride_mem [TABLE_DEPTH];
    logic  stride_vld [TABLE_DEPTH];
    addr_t ptr_mem [TABLE_DEPTH];
    logic  ptr_vld [TABLE_DEPTH];
    ctr2_t conf_m [TABLE_DEPTH];
    ctr2_t sel_m [TABLE_DEPTH];
    addr_t prev_addr;
    logic  prev_seen;
    logic  issuer_busy;
    int    pause_left;
    int    useless_run;

    addr_t       expected_q [$];
    addr_t       issued_q [$];
    int unsigned errors = 0;
    int unsigned cycles = 0;
    logic [31:0] lcg_state;
    int          ar_stall;

    pf_clk_gen i_pf_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    data_prefetch_top i_data_prefetch_top (.*);

    function automatic idx_t hash_index(input logic [31:0] value);
        return value[7:2] ^ value[13:8];
    endfunction

    function automatic ctr2_t saturate(input ctr2_t value, input logic up);
        if (up) begin
            return (value == 2'd3) ? value : value + 2'd1;
        end
        return (value == 2'd0) ? value : value - 2'd1;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report(input pc_t pc, input pf_kind_e kind, input logic useful);
        idx_t idx;
        idx = hash_index(pc);
        conf_m[idx] = saturate(conf_m[idx], useful);
        // pointer gains when a pointer report helped or a stride report did not
        sel_m[idx] = saturate(sel_m[idx], useful == (kind == pointer));
        fb_valid  = 1'b1;
        fb_pc     = pc;
        fb_kind   = kind;
        fb_useful = useful;
        next_cycle();
        fb_valid = 1'b0;
    endtask

    task automatic access(input pc_t pc, input addr_t addr);
        idx_t  pc_idx;
        idx_t  addr_idx;
        logic  hit;
        addr_t guess;
        logic  want;
        pc_idx   = hash_index(pc);
        addr_idx = hash_index(addr);
        if (sel_m[pc_idx][1]) begin
            hit   = ptr_vld[addr_idx];
            guess = ptr_mem[addr_idx];
        end else begin
            hit   = stride_vld[pc_idx];
            guess = addr + (addr - stride_mem[pc_idx]);
        end
        want = conf_m[pc_idx][1] && hit && (guess != addr);
        // lookup sees the tables before this access writes them
        if (prev_seen && prev_addr != addr) begin
            ptr_mem[hash_index(prev_addr)] = addr;
            ptr_vld[hash_index(prev_addr)] = 1'b1;
        end
        stride_mem[pc_idx] = addr;
        stride_vld[pc_idx] = 1'b1;
        prev_addr = addr;
        prev_seen = 1'b1;
        acc_valid = 1'b1;
        acc_pc    = pc;
        acc_addr  = addr;
        next_cycle();
        acc_valid = 1'b0;
        if (want && !issuer_busy && pause_left == 0) begin
            issuer_busy = 1'b1;
            expected_q.push_back(guess);
        end
    endtask

    // wait until the read channel is idle, then match reads against the model
    task automatic check_reads(input int want_n, input addr_t want_last, input string what);
        int    n;
        addr_t got;
        addr_t want;
        n   = 0;
        got = '0;
        next_cycle();
        next_cycle();
        while (arvalid || rready) begin
            next_cycle();
        end
        while (issued_q.size() > 0) begin
            got  = issued_q.pop_front();
            want = (expected_q.size() > 0) ? expected_q.pop_front() : ~got;
            n++;
            assert (got == want) else begin
                $display("** Error @%0t: %s read at 0x%08h, model gave 0x%08h",
                         $time, what, got, want);
                errors++;
            end
        end
        assert (expected_q.size() == 0) else begin
            $display("** Error @%0t: %s missed %0d reads", $time, what, expected_q.size());
            errors++;
        end
        expected_q.delete();
        assert (n == want_n && (n == 0 || got == want_last)) else begin
            $display("** Error @%0t: %s gave %0d reads ending at 0x%08h, expected %0d at 0x%08h",
                     $time, what, n, got, want_n, want_last);
            errors++;
        end
    endtask

    task automatic cold_start();
        assert (!arvalid && !rready) else begin
            $display("** Error @%0t: read channel active after reset", $time);
            errors++;
        end
        access(32'h1000_0004, 32'h0000_0104);
        check_reads(0, '0, "cold access");
    endtask

    task automatic stride_training();
        access(32'h1000_0008, 32'h0000_0200);
        check_reads(0, '0, "first stride access");
        access(32'h1000_0008, 32'h0000_0210);
        check_reads(1, 32'h0000_0220, "second stride access");
        access(32'h1000_0008, 32'h0000_0220);
        check_reads(1, 32'h0000_0230, "third stride access");
        access(32'h1000_000c, 32'h0000_0300);
        check_reads(0, '0, "new pc");
        access(32'h1000_000c, 32'h0000_0300);
        check_reads(0, '0, "repeated address");
    endtask

    task automatic pointer_chain();
        report(32'h1000_0010, pointer, 1'b1);
        report(32'h1000_0010, pointer, 1'b1);
        // first walk records successors, second walk uses them
        for (int walk = 0; walk < 2; walk++) begin
            access(32'h1000_0010, 32'h0002_0040);
            check_reads(walk == 1 ? 1 : 0, 32'h0002_0080, "chain P1");
            access(32'h1000_0010, 32'h0002_0080);
            check_reads(walk == 1 ? 1 : 0, 32'h0002_00c4, "chain P2");
            access(32'h1000_0010, 32'h0002_00c4);
            check_reads(walk == 1 ? 1 : 0, 32'h0002_0040, "chain P3");
        end
    endtask

    task automatic confidence_gating();
        report(32'h1000_0014, stride, 1'b0);
        report(32'h1000_0014, stride, 1'b0);
        access(32'h1000_0014, 32'h0000_0400);
        check_reads(0, '0, "low confidence 0");
        access(32'h1000_0014, 32'h0000_0420);
        check_reads(0, '0, "low confidence 1");
        access(32'h1000_0014, 32'h0000_0440);
        check_reads(0, '0, "low confidence 2");
        report(32'h1000_0014, stride, 1'b1);
        report(32'h1000_0014, stride, 1'b1);
        access(32'h1000_0014, 32'h0000_0460);
        check_reads(1, 32'h0000_0480, "restored confidence");
    endtask

    task automatic back_pressure();
        ar_stall = 6 + int'(lcg_next() % 8);
        access(32'h1000_0018, 32'h0000_0600);
        check_reads(0, '0, "stall setup");
        access(32'h1000_0018, 32'h0000_0608);
        access(32'h1000_0018, 32'h0000_0610);
        access(32'h1000_0018, 32'h0000_0618);
        access(32'h1000_0018, 32'h0000_0620);
        check_reads(1, 32'h0000_0610, "stalled read");
        ar_stall = 0;
    endtask

    task automatic throttle_pause();
        access(32'h1000_001c, 32'h0000_0700);
        check_reads(0, '0, "throttle setup");
        access(32'h1000_001c, 32'h0000_0704);
        check_reads(1, 32'h0000_0708, "before pause");
        for (int i = 8; i < 12; i++) begin
            report(32'h1000_0000 + 32'(i * 4), stride, 1'b0);
        end
        // first paused cycle, then the last one, then the first free one
        access(32'h1000_001c, 32'h0000_0708);
        repeat (29) next_cycle();
        access(32'h1000_001c, 32'h0000_070c);
        access(32'h1000_001c, 32'h0000_0710);
        check_reads(1, 32'h0000_0714, "after pause");
    endtask

    always @(posedge clk) begin
        if (rvalid) begin
            issuer_busy = 1'b0;
        end
        if (pause_left > 0) begin
            pause_left--;
        end
        if (fb_valid && !fb_useful) begin
            if (useless_run == THROTTLE_LIMIT - 1) begin
                useless_run = 0;
                pause_left  = THROTTLE_CYCLES;
            end else begin
                useless_run++;
            end
        end else if (fb_valid) begin
            useless_run = 0;
        end
    end

    // AXI4-Lite read slave with random latencies
    initial begin : axi_slave
        int    delay;
        addr_t held;
        forever begin
            next_cycle();
            if (arvalid === 1'b1) begin
                held  = araddr;
                delay = (ar_stall != 0) ? ar_stall : int'(lcg_next() % 3);
                repeat (delay) begin
                    next_cycle();
                    assert (arvalid && araddr == held) else begin
                        $display("** Error @%0t: AR changed during stall, araddr 0x%08h",
                                 $time, araddr);
                        errors++;
                    end
                end
                assert (arprot == 3'b000) else begin
                    $display("** Error @%0t: arprot is 0x%0h, expected 0x0", $time, arprot);
                    errors++;
                end
                arready = 1'b1;
                issued_q.push_back(araddr);
                next_cycle();
                arready = 1'b0;
                repeat (int'(lcg_next() % 3)) next_cycle();
                assert (rready) else begin
                    $display("** Error @%0t: rready low while the response is awaited",
                             $time);
                    errors++;
                end
                rvalid = 1'b1;
                rdata  = lcg_next();
                next_cycle();
                rvalid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        acc_valid   = 1'b0;
        acc_pc      = '0;
        acc_addr    = '0;
        fb_valid    = 1'b0;
        fb_pc       = '0;
        fb_kind     = stride;
        fb_useful   = 1'b0;
        arready     = 1'b0;
        rdata       = '0;
        rresp       = 2'b00;
        rvalid      = 1'b0;
        lcg_state   = 32'haadc;
        ar_stall    = 0;
        prev_addr   = '0;
        prev_seen   = 1'b0;
        issuer_busy = 1'b0;
        pause_left  = 0;
        useless_run = 0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            stride_vld[i] = 1'b0;
            ptr_vld[i]    = 1'b0;
            conf_m[i]     = CONF_INIT;
            sel_m[i]      = SEL_INIT;
        end
        @(posedge arst_n);
        cold_start();
        stride_training();
        pointer_chain();
        confidence_gating();
        back_pressure();
        throttle_pause();
        $display("errors: %0d in testbench checks, %0d in protocol assertions",
                 errors, i_data_prefetch_top.i_data_prefetch_checker.fail_count);
        if (errors == 0 && i_data_prefetch_top.i_data_prefetch_checker.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/data_prefetch_checker.sv
`timescale 1ns/1ps

module data_prefetch_checker import pf_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input addr_t araddr,
    input logic  arvalid,
    input logic  arready,
    input logic  rready
);

    int unsigned fail_count = 0;

    // AR request must hold until accepted
    ar_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    ) else begin
        fail_count++;
        $error("arvalid dropped or araddr changed before arready");
    end

    // rready rises only after an AR handshake and never beside arvalid
    r_after_ar: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(rready) |-> !arvalid && $past(arvalid && arready)
    ) else begin
        fail_count++;
        $error("rready rose without a preceding AR handshake or with arvalid high");
    end

    reset_idle: assert property (
        @(posedge clk)
        $rose(arst_n) |-> !arvalid && !rready
    ) else begin
        fail_count++;
        $error("read channel not idle in the first cycle after reset");
    end

endmodule

bind data_prefetch_top data_prefetch_checker i_data_prefetch_checker (.*);

//--- sim/pf_clk_gen.sv
`timescale 1ns/1ps

module pf_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // two cycles of reset, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- verilog/data_prefetch_top.sv
`timescale 1ns/1ps

module data_prefetch_top import pf_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    input  logic        acc_valid,
    input  pc_t         acc_pc,
    input  addr_t       acc_addr,

    input  logic        fb_valid,
    input  pc_t         fb_pc,
    input  pf_kind_e    fb_kind,
    input  logic        fb_useful,

    // AXI4-Lite read master, read data is dropped
    output addr_t       araddr,
    output logic [2:0]  arprot,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready
);

    pf_req_if req_if ();

    logic throttled;

    assign arprot = 3'b000;

    pf_predictor i_pf_predictor (
        .clk       (clk),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc_pc    (acc_pc),
        .acc_addr  (acc_addr),
        .fb_valid  (fb_valid),
        .fb_pc     (fb_pc),
        .fb_kind   (fb_kind),
        .fb_useful (fb_useful),
        .req       (req_if.source)
    );

    pf_issue_fsm i_pf_issue_fsm (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req_if.sink),
        .throttled (throttled),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    pf_throttle i_pf_throttle (
        .clk       (clk),
        .arst_n    (arst_n),
        .fb_valid  (fb_valid),
        .fb_useful (fb_useful),
        .throttled (throttled)
    );

endmodule

//--- verilog/pf_throttle.sv
`timescale 1ns/1ps

module pf_throttle import pf_pkg::*;
(
    input  logic clk,
    input  logic arst_n,
    input  logic fb_valid,
    input  logic fb_useful,
    output logic throttled
);

    useless_cnt_t useless_cnt;
    pause_cnt_t   pause_cnt;
    logic         limit_hit;

    assign limit_hit = fb_valid && !fb_useful
                       && (useless_cnt == useless_cnt_t'(THROTTLE_LIMIT - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            useless_cnt <= '0;
            pause_cnt   <= '0;
        end else begin
            if (fb_valid) begin
                if (fb_useful || limit_hit) begin
                    useless_cnt <= '0;
                end else begin
                    useless_cnt <= useless_cnt + 1'b1;
                end
            end
            // pause starts the cycle after the limiting report
            if (limit_hit) begin
                pause_cnt <= pause_cnt_t'(THROTTLE_CYCLES);
            end else if (pause_cnt != '0) begin
                pause_cnt <= pause_cnt - 1'b1;
            end
        end
    end

    assign throttled = (pause_cnt != '0);

endmodule

//--- verilog/pf_issue_fsm.sv
`timescale 1ns/1ps

module pf_issue_fsm import pf_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    pf_req_if.sink req,
    input  logic   throttled,
    output addr_t  araddr,
    output logic   arvalid,
    input  logic   arready,
    input  logic   rvalid,
    output logic   rready
);

    issue_state_e state;
    issue_state_e state_nxt;
    logic         accept;

    // only one read in flight, new requests are dropped meanwhile
    assign req.ready = (state == idle) && !throttled;
    assign accept    = req.valid && req.ready;

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (accept) begin
                    state_nxt = addr_phase;
                end
            end
            addr_phase: begin
                if (arready) begin
                    state_nxt = data_phase;
                end
            end
            data_phase: begin
                if (rvalid) begin
                    state_nxt = idle;
                end
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // address held stable through the AR stall
    always_ff @(posedge clk) begin
        if (accept) begin
            araddr <= req.addr;
        end
    end

    assign arvalid = (state == addr_phase);
    assign rready  = (state == data_phase);

endmodule

//--- verilog/pf_predictor.sv
`timescale 1ns/1ps

module pf_predictor import pf_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     acc_valid,
    input  pc_t      acc_pc,
    input  addr_t    acc_addr,
    input  logic     fb_valid,
    input  pc_t      fb_pc,
    input  pf_kind_e fb_kind,
    input  logic     fb_useful,
    pf_req_if.source req
);

    idx_t  acc_idx;
    idx_t  addr_idx;
    idx_t  last_idx;
    idx_t  fb_idx;

    addr_t stride_rdata;
    logic  stride_hit;
    addr_t pointer_rdata;
    logic  pointer_hit;
    logic  pointer_we;

    ctr2_t conf [TABLE_DEPTH];
    ctr2_t sel  [TABLE_DEPTH];

    // previous access, also the stage register of the current one
    addr_t last_addr;
    logic  last_seen;
    logic  acc_valid_q;
    logic  conf_en_q;
    logic  sel_ptr_q;

    addr_t stride_pred;
    addr_t chosen_addr;
    logic  chosen_hit;
    logic  sel_up;

    assign acc_idx  = pf_hash(acc_pc);
    assign addr_idx = pf_hash(acc_addr);
    assign last_idx = pf_hash(last_addr);
    assign fb_idx   = pf_hash(fb_pc);

    // pointer entry records which address followed the last one
    assign pointer_we = acc_valid && last_seen && (last_addr != acc_addr);

    pf_table stride_tbl (
        .clk        (clk),
        .arst_n     (arst_n),
        .raddr      (acc_idx),
        .rdata      (stride_rdata),
        .rvalid_bit (stride_hit),
        .we         (acc_valid),
        .waddr      (acc_idx),
        .wdata      (acc_addr)
    );

    pf_table pointer_tbl (
        .clk        (clk),
        .arst_n     (arst_n),
        .raddr      (addr_idx),
        .rdata      (pointer_rdata),
        .rvalid_bit (pointer_hit),
        .we         (pointer_we),
        .waddr      (last_idx),
        .wdata      (acc_addr)
    );

    // selector moves toward fb_kind when useful, away otherwise
    assign sel_up = (fb_useful == (fb_kind == pointer));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                conf[i] <= CONF_INIT;
                sel[i]  <= SEL_INIT;
            end
        end else if (fb_valid) begin
            conf[fb_idx] <= fb_useful ? ctr_inc(conf[fb_idx]) : ctr_dec(conf[fb_idx]);
            sel[fb_idx]  <= sel_up ? ctr_inc(sel[fb_idx]) : ctr_dec(sel[fb_idx]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid_q <= 1'b0;
            last_seen   <= 1'b0;
            conf_en_q   <= 1'b0;
            sel_ptr_q   <= 1'b0;
        end else begin
            acc_valid_q <= acc_valid;
            if (acc_valid) begin
                last_seen <= 1'b1;
                conf_en_q <= conf[acc_idx][1];
                sel_ptr_q <= sel[acc_idx][1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            last_addr <= acc_addr;
        end
    end

    // addr + (addr - previous addr of this pc)
    assign stride_pred = last_addr + (last_addr - stride_rdata);

    assign chosen_addr = sel_ptr_q ? pointer_rdata : stride_pred;
    assign chosen_hit  = sel_ptr_q ? pointer_hit : stride_hit;

    assign req.valid = acc_valid_q && conf_en_q && chosen_hit && (chosen_addr != last_addr);
    assign req.addr  = chosen_addr;
    assign req.kind  = sel_ptr_q ? pointer : stride;

endmodule

//--- verilog/pf_table.sv
`timescale 1ns/1ps

module pf_table import pf_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  idx_t  raddr,
    output addr_t rdata,
    output logic  rvalid_bit,
    input  logic  we,
    input  idx_t  waddr,
    input  addr_t wdata
);

    addr_t                  mem [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] valid_q;

    // read-first, a colliding write is seen next time
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q    <= '0;
            rvalid_bit <= 1'b0;
        end else begin
            rvalid_bit <= valid_q[raddr];
            if (we) begin
                valid_q[waddr] <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/pf_req_if.sv
`timescale 1ns/1ps

// one-cycle prediction request, lost when ready is low
interface pf_req_if import pf_pkg::*;
();

    logic     valid;
    logic     ready;
    addr_t    addr;
    pf_kind_e kind;

    modport source (
        output valid,
        output addr,
        output kind,
        input  ready
    );

    modport sink (
        input  valid,
        input  addr,
        input  kind,
        output ready
    );

endinterface

//--- verilog/pf_pkg.sv
package pf_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] pc_t;
    typedef logic [5:0]  idx_t;

    // saturating counter, upper bit is the decision
    typedef logic [1:0]  ctr2_t;

    typedef logic [2:0]  useless_cnt_t;
    typedef logic [5:0]  pause_cnt_t;

    typedef enum logic {
        stride  = 1'b0,
        pointer = 1'b1
    } pf_kind_e;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        addr_phase = 2'd1,
        data_phase = 2'd2
    } issue_state_e;

    localparam int TABLE_DEPTH = 64;

    // weakly enabled / strongly stride
    localparam ctr2_t CONF_INIT = 2'b10;
    localparam ctr2_t SEL_INIT  = 2'b00;

    localparam int THROTTLE_LIMIT  = 4;
    localparam int THROTTLE_CYCLES = 32;

    function automatic idx_t pf_hash(input logic [31:0] value);
        return value[7:2] ^ value[13:8];
    endfunction

    function automatic ctr2_t ctr_inc(input ctr2_t value);
        return (value == 2'b11) ? value : ctr2_t'(value + 2'd1);
    endfunction

    function automatic ctr2_t ctr_dec(input ctr2_t value);
        return (value == 2'b00) ? value : ctr2_t'(value - 2'd1);
    endfunction

endpackage
